//--- build.f
source/usb_line_pkg.sv
source/usb_link_pkg.sv
source/usb_us_tick.sv
source/usb_glitch_filter.sv
source/usbdev_linkstate.sv
source/usb_link_events.sv
source/usb_link_monitor.sv
tests/tb_clkgen.sv
tests/usb_link_monitor_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the USB link monitor testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot change to the project root"
  exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -j 0 -f build.f \
  --top-module usb_link_monitor_tb -o sim_usb_link_monitor
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_usb_link_monitor > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
fi
exit 1

//--- source/usb_glitch_filter.sv
`timescale 1ns/100ps

module usb_glitch_filter #(
  parameter int Cycles = 4
) (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic filter_i,
  output logic filter_o
);

  localparam int CntW = $clog2(Cycles + 1);

  logic            sample_q;
  logic [CntW-1:0] stable_cnt_q;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sample_q     <= 1'b0;
      stable_cnt_q <= '0;
      filter_o     <= 1'b0;
    end else begin
      sample_q <= filter_i;
      // Any change restarts the stability count
      if (filter_i != sample_q) begin
        stable_cnt_q <= '0;
      end else if (stable_cnt_q != CntW'(Cycles)) begin
        stable_cnt_q <= stable_cnt_q + 1'b1;
      end
      // Held long enough, pass the level on
      if (stable_cnt_q == CntW'(Cycles)) begin
        filter_o <= sample_q;
      end
    end
  end

endmodule

//--- source/usb_line_pkg.sv
package usb_line_pkg;

  //////////////////////////////////////////////////////////
  // Line sampling
  //////////////////////////////////////////////////////////

  // Clock cycles per microsecond tick at 48 MHz
  localparam logic [5:0] TickDivide = 6'd48;

  // Stable samples needed before a filter output follows its input
  localparam int FilterCycles = 6;

  //////////////////////////////////////////////////////////
  // Event word layout
  //////////////////////////////////////////////////////////

  localparam int EvtWidth = 4;

  // Bit positions within the event word
  localparam logic [1:0] EvtResume     = 2'd0;
  localparam logic [1:0] EvtSofMissed  = 2'd1;
  localparam logic [1:0] EvtHostLost   = 2'd2;
  localparam logic [1:0] EvtDisconnect = 2'd3;

endpackage

//--- source/usb_link_events.sv
`timescale 1ns/100ps

module usb_link_events (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic link_resume_i,
  input  logic sof_missed_i,
  input  logic host_lost_i,
  input  logic link_disconnect_i,
  input  logic evt_ack_i,
  output logic evt_req_o,
  output logic [usb_line_pkg::EvtWidth-1:0] evt_word_o
);

  logic                              host_lost_q;
  logic                              disconnect_q;
  logic [usb_line_pkg::EvtWidth-1:0] evt_set;
  logic [usb_line_pkg::EvtWidth-1:0] pending_q;
  logic                              launch;

  // One pulse per event, level inputs on their rising edge
  always_comb begin
    evt_set                              = '0;
    evt_set[usb_line_pkg::EvtResume]     = link_resume_i;
    evt_set[usb_line_pkg::EvtSofMissed]  = sof_missed_i;
    evt_set[usb_line_pkg::EvtHostLost]   = host_lost_i && !host_lost_q;
    evt_set[usb_line_pkg::EvtDisconnect] = link_disconnect_i && !disconnect_q;
  end

  // New request only with the previous handshake fully closed
  assign launch = !evt_req_o && !evt_ack_i && (pending_q != '0);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Link comes out of reset disconnected, no edge there
      host_lost_q  <= 1'b0;
      disconnect_q <= 1'b1;
      pending_q    <= '0;
      evt_req_o    <= 1'b0;
    end else begin
      host_lost_q  <= host_lost_i;
      disconnect_q <= link_disconnect_i;
      // Captured bits leave pending, events of this cycle stay
      pending_q    <= (launch ? '0 : pending_q) | evt_set;
      if (launch) begin
        evt_req_o <= 1'b1;
      end else if (evt_ack_i) begin
        evt_req_o <= 1'b0;
      end
    end
  end

  // Payload register
  always_ff @(posedge clk_48mhz_i) begin
    if (launch) begin
      evt_word_o <= pending_q;
    end
  end

  // Word holds for the whole request
  WordStable_A: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    evt_req_o |=> !evt_req_o || $stable(evt_word_o));
  // No new request while the consumer still acks the old one
  ReqAfterAckLow_A: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !evt_req_o && evt_ack_i |=> !evt_req_o);

endmodule

//--- source/usb_link_monitor.sv
`timescale 1ns/100ps

module usb_link_monitor (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic usb_sense_i,
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_oe_i,
  input  logic usb_pullup_en_i,
  input  logic rx_idle_det_i,
  input  logic rx_j_det_i,
  input  logic sof_detected_i,
  input  logic resume_link_active_i,
  input  logic evt_ack_i,

  output logic link_disconnect_o,
  output logic link_powered_o,
  output logic link_reset_o,
  output logic link_active_o,
  output logic link_suspend_o,
  output logic link_resume_o,
  output logic host_lost_o,
  output logic sof_missed_o,
  output usb_link_pkg::link_state_e link_state_o,

  output logic evt_req_o,
  output logic [usb_line_pkg::EvtWidth-1:0] evt_word_o
);

  logic us_tick;
  logic line_se0_raw;
  logic see_se0;
  logic see_pwr;

  // SE0 only counts while the device is not driving the bus
  assign line_se0_raw = !usb_dp_i && !usb_dn_i && !usb_oe_i;

  usb_us_tick u_us_tick (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .tick_o      (us_tick)
  );

  ////////////////////////////////////////////////////////////
  // Line filters
  ////////////////////////////////////////////////////////////

  usb_glitch_filter #(
    .Cycles (usb_line_pkg::FilterCycles)
  ) u_filter_se0 (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .filter_i    (line_se0_raw),
    .filter_o    (see_se0)
  );

  usb_glitch_filter #(
    .Cycles (usb_line_pkg::FilterCycles)
  ) u_filter_pwr (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .filter_i    (usb_sense_i),
    .filter_o    (see_pwr)
  );

  usbdev_linkstate u_linkstate (
    .clk_48mhz_i          (clk_48mhz_i),
    .rst_ni               (rst_ni),
    .us_tick_i            (us_tick),
    .see_se0_i            (see_se0),
    .see_pwr_i            (see_pwr),
    .usb_pullup_en_i      (usb_pullup_en_i),
    .rx_idle_det_i        (rx_idle_det_i),
    .rx_j_det_i           (rx_j_det_i),
    .sof_detected_i       (sof_detected_i),
    .resume_link_active_i (resume_link_active_i),
    .link_disconnect_o    (link_disconnect_o),
    .link_powered_o       (link_powered_o),
    .link_reset_o         (link_reset_o),
    .link_active_o        (link_active_o),
    .link_suspend_o       (link_suspend_o),
    .link_resume_o        (link_resume_o),
    .host_lost_o          (host_lost_o),
    .sof_missed_o         (sof_missed_o),
    .link_state_o         (link_state_o)
  );

  // Software side of the link events
  usb_link_events u_link_events (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_resume_i     (link_resume_o),
    .sof_missed_i      (sof_missed_o),
    .host_lost_i       (host_lost_o),
    .link_disconnect_i (link_disconnect_o),
    .evt_ack_i         (evt_ack_i),
    .evt_req_o         (evt_req_o),
    .evt_word_o        (evt_word_o)
  );

endmodule

//--- source/usb_link_pkg.sv
package usb_link_pkg;

  // Link state encoding, also visible to software
  typedef enum logic [2:0] {
    // No power or no pull-up
    LinkDisconnected     = 3'd0,
    // Powered, not yet reset by the host
    LinkPowered          = 3'd1,
    LinkPoweredSuspended = 3'd2,
    // Active states
    LinkActive           = 3'd3,
    LinkSuspended        = 3'd4,
    LinkActiveNoSof      = 3'd5,
    LinkResuming         = 3'd6
  } link_state_e;

  //////////////////////////////////////////////////////////
  // Protocol timeouts in microseconds
  //////////////////////////////////////////////////////////

  // Idle J for 3 ms puts the device into suspend
  localparam logic [11:0] SuspendTimeoutUs = 12'd3000;
  // SE0 longer than this is a bus reset, shorter ones end resume signaling
  localparam logic [2:0]  ResetTimeoutUs   = 3'd3;
  // One frame plus margin for host and device clock tolerance
  localparam logic [9:0]  SofTimeoutUs     = 10'd1005;
  // Missed frames in a row before the host counts as gone
  localparam logic [2:0]  HostLostFrames   = 3'd4;

endpackage

//--- source/usb_us_tick.sv
`timescale 1ns/100ps

module usb_us_tick (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  output logic tick_o
);

  logic [5:0] div_cnt_q;
  logic       wrap;

  // Last count of the microsecond period
  assign wrap = (div_cnt_q == usb_line_pkg::TickDivide - 6'd1);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_cnt_q <= '0;
      tick_o    <= 1'b0;
    end else begin
      div_cnt_q <= wrap ? 6'd0 : div_cnt_q + 6'd1;
      // Registered pulse, first one 48 cycles after reset release
      tick_o    <= wrap;
    end
  end

  // Tick is a single-cycle pulse
  TickPulse_A: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    tick_o |=> !tick_o);

endmodule

//--- source/usbdev_linkstate.sv
`timescale 1ns/100ps

module usbdev_linkstate (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic us_tick_i,
  input  logic see_se0_i,
  input  logic see_pwr_i,
  input  logic usb_pullup_en_i,
  input  logic rx_idle_det_i,
  input  logic rx_j_det_i,
  input  logic sof_detected_i,
  input  logic resume_link_active_i,

  output logic link_disconnect_o,
  output logic link_powered_o,
  output logic link_reset_o,
  output logic link_active_o,
  output logic link_suspend_o,
  output logic link_resume_o,
  output logic host_lost_o,
  output logic sof_missed_o,

  output usb_link_pkg::link_state_e link_state_o
);

  typedef enum logic [1:0] {
    NoRst   = 2'd0,
    RstCnt  = 2'd1,
    RstPend = 2'd2
  } rst_state_e;

  typedef enum logic [1:0] {
    Active    = 2'd0,
    InactCnt  = 2'd1,
    InactPend = 2'd2
  } inac_state_e;

  usb_link_pkg::link_state_e link_state_d, link_state_q;

  // Reset detector
  rst_state_e  rst_state_d, rst_state_q;
  logic [2:0]  rst_timer_d, rst_timer_q;
  logic        ev_reset;

  // Inactivity detector
  inac_state_e inac_state_d, inac_state_q;
  logic [11:0] inac_timer_d, inac_timer_q;
  logic        monitor_inac;
  logic        ev_bus_inactive;
  logic        ev_bus_active;

  // SOF timer and missed-frame count
  logic [9:0]  sof_timer_q;
  logic [2:0]  missed_cnt_q;

  assign link_state_o      = link_state_q;
  assign link_disconnect_o = (link_state_q == usb_link_pkg::LinkDisconnected);
  assign link_powered_o    = see_pwr_i;
  assign link_active_o     = (link_state_q == usb_link_pkg::LinkActive) ||
                             (link_state_q == usb_link_pkg::LinkActiveNoSof);
  assign link_suspend_o    = (link_state_q == usb_link_pkg::LinkSuspended) ||
                             (link_state_q == usb_link_pkg::LinkPoweredSuspended);

  // Anything but idle from the receiver is bus activity
  assign ev_bus_active = !rx_idle_det_i;
  // Idle only matters while powered or active
  assign monitor_inac  = see_pwr_i &&
                         ((link_state_q == usb_link_pkg::LinkPowered) || link_active_o);

  ////////////////////////////////////////////////////////////
  // Link state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    link_state_d  = link_state_q;
    link_resume_o = 1'b0;
    // Losing VBUS or the pull-up always wins
    if (!see_pwr_i || !usb_pullup_en_i) begin
      link_state_d = usb_link_pkg::LinkDisconnected;
    end else begin
      unique case (link_state_q)
        usb_link_pkg::LinkDisconnected: begin
          link_state_d = usb_link_pkg::LinkPowered;
        end
        usb_link_pkg::LinkPowered: begin
          if (ev_reset) begin
            link_state_d = usb_link_pkg::LinkActiveNoSof;
          end else if (resume_link_active_i) begin
            // Software restores a link that was suspended before power-down
            link_state_d = usb_link_pkg::LinkResuming;
          end else if (ev_bus_inactive) begin
            link_state_d = usb_link_pkg::LinkPoweredSuspended;
          end
        end
        usb_link_pkg::LinkPoweredSuspended: begin
          if (ev_reset) begin
            link_state_d = usb_link_pkg::LinkActiveNoSof;
          end else if (ev_bus_active) begin
            link_resume_o = 1'b1;
            link_state_d  = usb_link_pkg::LinkPowered;
          end
        end
        // Wait for a J after resume signaling before expecting frames
        usb_link_pkg::LinkResuming: begin
          if (rx_j_det_i || ev_reset) begin
            link_resume_o = 1'b1;
            link_state_d  = usb_link_pkg::LinkActiveNoSof;
          end
        end
        usb_link_pkg::LinkActiveNoSof: begin
          if (ev_bus_inactive) begin
            link_state_d = usb_link_pkg::LinkSuspended;
          end else if (sof_detected_i) begin
            link_state_d = usb_link_pkg::LinkActive;
          end
        end
        usb_link_pkg::LinkActive: begin
          if (ev_bus_inactive) begin
            link_state_d = usb_link_pkg::LinkSuspended;
          end else if (ev_reset) begin
            link_state_d = usb_link_pkg::LinkActiveNoSof;
          end
        end
        usb_link_pkg::LinkSuspended: begin
          if (ev_reset) begin
            link_resume_o = 1'b1;
            link_state_d  = usb_link_pkg::LinkActiveNoSof;
          end else if (ev_bus_active) begin
            link_state_d = usb_link_pkg::LinkResuming;
          end
        end
        default: link_state_d = usb_link_pkg::LinkDisconnected;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Reset detector
  ////////////////////////////////////////////////////////////

  always_comb begin
    rst_state_d  = rst_state_q;
    rst_timer_d  = rst_timer_q;
    ev_reset     = 1'b0;
    link_reset_o = 1'b0;
    unique case (rst_state_q)
      NoRst: begin
        if (see_se0_i) begin
          rst_state_d = RstCnt;
          rst_timer_d = 3'd0;
        end
      end
      // Short SE0 such as an EOP drops back out
      RstCnt: begin
        if (!see_se0_i) begin
          rst_state_d = NoRst;
        end else if (us_tick_i) begin
          if (rst_timer_q == usb_link_pkg::ResetTimeoutUs) begin
            rst_state_d = RstPend;
          end else begin
            rst_timer_d = rst_timer_q + 3'd1;
          end
        end
      end
      // Reset held, event fires when SE0 ends
      RstPend: begin
        link_reset_o = 1'b1;
        if (!see_se0_i) begin
          rst_state_d = NoRst;
          ev_reset    = 1'b1;
        end
      end
      default: rst_state_d = NoRst;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Inactivity detector
  ////////////////////////////////////////////////////////////

  always_comb begin
    inac_state_d    = inac_state_q;
    inac_timer_d    = inac_timer_q;
    ev_bus_inactive = 1'b0;
    unique case (inac_state_q)
      Active: begin
        inac_timer_d = 12'd0;
        if (!ev_bus_active && monitor_inac) begin
          inac_state_d = InactCnt;
        end
      end
      InactCnt: begin
        if (ev_bus_active || !monitor_inac) begin
          inac_state_d = Active;
        end else if (us_tick_i) begin
          if (inac_timer_q == usb_link_pkg::SuspendTimeoutUs) begin
            inac_state_d    = InactPend;
            ev_bus_inactive = 1'b1;
          end else begin
            inac_timer_d = inac_timer_q + 12'd1;
          end
        end
      end
      // One event per idle period
      InactPend: begin
        if (ev_bus_active || !monitor_inac) begin
          inac_state_d = Active;
        end
      end
      default: inac_state_d = Active;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      link_state_q <= usb_link_pkg::LinkDisconnected;
      rst_state_q  <= NoRst;
      rst_timer_q  <= 3'd0;
      inac_state_q <= Active;
      inac_timer_q <= 12'd0;
    end else begin
      link_state_q <= link_state_d;
      rst_state_q  <= rst_state_d;
      rst_timer_q  <= rst_timer_d;
      inac_state_q <= inac_state_d;
      inac_timer_q <= inac_timer_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // SOF timer and host loss
  ////////////////////////////////////////////////////////////

  assign sof_missed_o = (sof_timer_q == usb_link_pkg::SofTimeoutUs);
  assign host_lost_o  = (missed_cnt_q == usb_link_pkg::HostLostFrames);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sof_timer_q  <= 10'd0;
      missed_cnt_q <= 3'd0;
    end else begin
      // Restart on each frame, on a miss, and outside the active states
      if (sof_missed_o || sof_detected_i || !link_active_o || link_reset_o) begin
        sof_timer_q <= 10'd0;
      end else if (us_tick_i) begin
        sof_timer_q <= sof_timer_q + 10'd1;
      end
      if (sof_detected_i || !link_active_o || link_reset_o) begin
        missed_cnt_q <= 3'd0;
      end else if (sof_missed_o && !host_lost_o) begin
        missed_cnt_q <= missed_cnt_q + 3'd1;
      end
    end
  end

  // Legal encodings only in all three state registers
  LinkStateValid_A: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    link_state_q inside {usb_link_pkg::LinkDisconnected, usb_link_pkg::LinkPowered,
                         usb_link_pkg::LinkPoweredSuspended, usb_link_pkg::LinkActive,
                         usb_link_pkg::LinkSuspended, usb_link_pkg::LinkActiveNoSof,
                         usb_link_pkg::LinkResuming});
  RstStateValid_A: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    rst_state_q inside {NoRst, RstCnt, RstPend});
  InacStateValid_A: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    inac_state_q inside {Active, InactCnt, InactPend});

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  localparam int HalfPeriodNs = 20;
  localparam int ResetCycles  = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- tests/usb_link_monitor_tb.sv
`timescale 1ns/100ps

module usb_link_monitor_tb;

  localparam int UsCycles      = int'(usb_line_pkg::TickDivide);
  // Filter delay plus the registered state update
  localparam int SettleCycles  = usb_line_pkg::FilterCycles + 4;
  localparam int EvtWaitCycles = 60;
  // Test lengths in microseconds
  localparam int ResetSe0Us    = 10;
  localparam int SuspendWaitUs = int'(usb_link_pkg::SuspendTimeoutUs) + 3;
  localparam int MissWaitUs    = int'(usb_link_pkg::HostLostFrames) *
                                 int'(usb_link_pkg::SofTimeoutUs) + 20;
  localparam int MarginUs      = 100;
  localparam int WatchdogUs    = ResetSe0Us + 1 + SuspendWaitUs + MissWaitUs + MarginUs;

  // Positions in the level vector
  localparam logic [2:0] LvlDisconnect = 3'd0;
  localparam logic [2:0] LvlPowered    = 3'd1;
  localparam logic [2:0] LvlReset      = 3'd2;
  localparam logic [2:0] LvlActive     = 3'd3;
  localparam logic [2:0] LvlSuspend    = 3'd4;
  localparam logic [2:0] LvlHostLost   = 3'd5;
  localparam logic [2:0] LvlResume     = 3'd6;

  logic clk_48mhz;
  logic rst_n;

  // DUT inputs
  logic usb_sense;
  logic usb_dp;
  logic usb_dn;
  logic usb_oe;
  logic usb_pullup_en;
  logic rx_idle_det;
  logic rx_j_det;
  logic sof_detected;
  logic resume_link_active;
  logic evt_ack;

  // DUT outputs
  logic link_disconnect;
  logic link_powered;
  logic link_reset;
  logic link_active;
  logic link_suspend;
  logic link_resume;
  logic host_lost;
  logic sof_missed;
  logic evt_req;
  logic [usb_line_pkg::EvtWidth-1:0] evt_word;
  usb_link_pkg::link_state_e link_state;
  logic [6:0] link_levels;

  string test_name;
  int    errors = 0;
  int    seed = 62;

  // Check strobes with their expected values
  logic state_chk;
  logic lvl_chk;
  logic evt_chk;
  logic miss_chk;
  usb_link_pkg::link_state_e exp_state;
  logic [2:0] lvl_idx;
  logic       exp_level;
  logic [usb_line_pkg::EvtWidth-1:0] exp_evts;
  int         exp_misses;

  // Observed since the last clear
  logic clear_obs;
  logic [usb_line_pkg::EvtWidth-1:0] seen_evts;
  int         misses_seen;

  assign link_levels = {link_resume, host_lost, link_suspend, link_active,
                        link_reset, link_powered, link_disconnect};

  tb_clkgen u_clkgen (
    .clk_o  (clk_48mhz),
    .rst_no (rst_n)
  );

  usb_link_monitor DUT (
    .clk_48mhz_i          (clk_48mhz),
    .rst_ni               (rst_n),
    .usb_sense_i          (usb_sense),
    .usb_dp_i             (usb_dp),
    .usb_dn_i             (usb_dn),
    .usb_oe_i             (usb_oe),
    .usb_pullup_en_i      (usb_pullup_en),
    .rx_idle_det_i        (rx_idle_det),
    .rx_j_det_i           (rx_j_det),
    .sof_detected_i       (sof_detected),
    .resume_link_active_i (resume_link_active),
    .evt_ack_i            (evt_ack),
    .link_disconnect_o    (link_disconnect),
    .link_powered_o       (link_powered),
    .link_reset_o         (link_reset),
    .link_active_o        (link_active),
    .link_suspend_o       (link_suspend),
    .link_resume_o        (link_resume),
    .host_lost_o          (host_lost),
    .sof_missed_o         (sof_missed),
    .link_state_o         (link_state),
    .evt_req_o            (evt_req),
    .evt_word_o           (evt_word)
  );

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  StateCheck_A: assert property (@(posedge clk_48mhz) state_chk |-> link_state == exp_state)
    else begin
      errors++;
      $display("error %s: link state expected %0d actual %0d",
               test_name, exp_state, link_state);
    end

  LevelCheck_A: assert property (@(posedge clk_48mhz)
    lvl_chk |-> link_levels[lvl_idx] == exp_level)
    else begin
      errors++;
      $display("error %s: level %0d expected %0b actual %0b",
               test_name, lvl_idx, exp_level, link_levels[lvl_idx]);
    end

  // Every injected event shows up in some reported word
  EventSeen_A: assert property (@(posedge clk_48mhz)
    evt_chk |-> (seen_evts & exp_evts) == exp_evts)
    else begin
      errors++;
      $display("error %s: events expected %b actual %b",
               test_name, exp_evts, seen_evts & exp_evts);
    end

  MissCount_A: assert property (@(posedge clk_48mhz) miss_chk |-> misses_seen == exp_misses)
    else begin
      errors++;
      $display("error %s: missed frames expected %0d actual %0d",
               test_name, exp_misses, misses_seen);
    end

  // Request and word hold until the ack arrives
  WordHold_A: assert property (@(posedge clk_48mhz) disable iff (!rst_n)
    evt_req && !evt_ack |=> evt_req && $stable(evt_word))
    else begin
      errors++;
      $display("The event request or word changed before the ack");
    end

  ReqDrop_A: assert property (@(posedge clk_48mhz) disable iff (!rst_n)
    evt_req && evt_ack |=> !evt_req)
    else begin
      errors++;
      $display("The event request stayed high after the ack");
    end

  SofMissPulse_A: assert property (@(posedge clk_48mhz) disable iff (!rst_n)
    sof_missed |=> !sof_missed)
    else begin
      errors++;
      $display("The missed SOF pulse lasted more than one cycle");
    end

  // One SOF is enough to clear host loss
  HostLostClear_A: assert property (@(posedge clk_48mhz) disable iff (!rst_n)
    host_lost && sof_detected |=> !host_lost)
    else begin
      errors++;
      $display("Host loss did not clear after an SOF");
    end

  ////////////////////////////////////////////////////////////
  // Observers and consumer
  ////////////////////////////////////////////////////////////

  // Sampled mid-cycle where outputs are settled
  always @(negedge clk_48mhz) begin
    if (clear_obs) begin
      seen_evts   <= '0;
      misses_seen <= 0;
    end else begin
      if (evt_req && evt_ack) begin
        seen_evts <= seen_evts | evt_word;
      end
      if (sof_missed) begin
        misses_seen <= misses_seen + 1;
      end
    end
  end

  // Slow consumer with a random ack delay
  always begin : ack_responder
    int gap;
    @(negedge clk_48mhz);
    if (evt_req && !evt_ack) begin
      gap = random_gap(20);
      repeat (gap) @(posedge clk_48mhz);
      @(posedge clk_48mhz);
      evt_ack <= 1'b1;
      do @(negedge clk_48mhz); while (evt_req);
      @(posedge clk_48mhz);
      evt_ack <= 1'b0;
    end
  end

  // Ends a hung run
  initial begin : watchdog
    repeat (WatchdogUs * UsCycles) @(posedge clk_48mhz);
    $display("Run timed out after %0d us with %0d errors", WatchdogUs, errors);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int random_gap(input int max_gap);
    int unsigned r;
    r = $unsigned($random(seed));
    return int'(r % $unsigned(max_gap + 1));
  endfunction

  function automatic logic [usb_line_pkg::EvtWidth-1:0] event_mask(input logic [1:0] pos);
    logic [usb_line_pkg::EvtWidth-1:0] mask;
    mask      = '0;
    mask[pos] = 1'b1;
    return mask;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_48mhz);
  endtask

  task automatic wait_us(input int n);
    wait_cycles(n * UsCycles);
  endtask

  task automatic clear_observed();
    clear_obs <= 1'b1;
    @(posedge clk_48mhz);
    clear_obs <= 1'b0;
  endtask

  task automatic pulse_sof();
    sof_detected <= 1'b1;
    @(posedge clk_48mhz);
    sof_detected <= 1'b0;
  endtask

  // Strobe raised here is sampled on the next edge
  task automatic expect_state(input usb_link_pkg::link_state_e st);
    exp_state <= st;
    state_chk <= 1'b1;
    @(posedge clk_48mhz);
    state_chk <= 1'b0;
  endtask

  task automatic expect_level(input logic [2:0] idx, input logic val);
    lvl_idx   <= idx;
    exp_level <= val;
    lvl_chk   <= 1'b1;
    @(posedge clk_48mhz);
    lvl_chk   <= 1'b0;
  endtask

  task automatic expect_misses(input int n);
    exp_misses <= n;
    miss_chk   <= 1'b1;
    @(posedge clk_48mhz);
    miss_chk   <= 1'b0;
  endtask

  // Waits for the handshake to deliver the bits, bounded
  task automatic expect_events(input logic [usb_line_pkg::EvtWidth-1:0] mask);
    int waited;
    waited = 0;
    while (((seen_evts & mask) != mask) && (waited < EvtWaitCycles)) begin
      @(posedge clk_48mhz);
      waited++;
    end
    exp_evts <= mask;
    evt_chk  <= 1'b1;
    @(posedge clk_48mhz);
    evt_chk  <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    // Idle J on the bus, device not driving
    usb_sense          <= 1'b0;
    usb_dp             <= 1'b1;
    usb_dn             <= 1'b0;
    usb_oe             <= 1'b0;
    usb_pullup_en      <= 1'b0;
    rx_idle_det        <= 1'b0;
    rx_j_det           <= 1'b0;
    sof_detected       <= 1'b0;
    resume_link_active <= 1'b0;
    evt_ack            <= 1'b0;
    state_chk          <= 1'b0;
    lvl_chk            <= 1'b0;
    evt_chk            <= 1'b0;
    miss_chk           <= 1'b0;
    exp_state          <= usb_link_pkg::LinkDisconnected;
    lvl_idx            <= LvlDisconnect;
    exp_level          <= 1'b0;
    exp_evts           <= '0;
    exp_misses         <= 0;
    clear_obs          <= 1'b1;
    test_name = "reset";
    wait (rst_n);
    @(posedge clk_48mhz);
    clear_obs <= 1'b0;
    expect_state(usb_link_pkg::LinkDisconnected);
    expect_level(LvlDisconnect, 1'b1);
    expect_level(LvlActive, 1'b0);

    // Attach, unplug, attach again
    test_name = "attach";
    usb_sense     <= 1'b1;
    usb_pullup_en <= 1'b1;
    wait_cycles(SettleCycles);
    expect_state(usb_link_pkg::LinkPowered);
    expect_level(LvlPowered, 1'b1);
    clear_observed();
    usb_sense <= 1'b0;
    wait_cycles(SettleCycles);
    expect_state(usb_link_pkg::LinkDisconnected);
    expect_events(event_mask(usb_line_pkg::EvtDisconnect));
    usb_sense <= 1'b1;
    wait_cycles(SettleCycles);
    expect_state(usb_link_pkg::LinkPowered);

    // Long SE0 is a bus reset
    test_name = "bus_reset";
    usb_dp <= 1'b0;
    wait_us(ResetSe0Us);
    expect_level(LvlReset, 1'b1);
    expect_state(usb_link_pkg::LinkPowered);
    usb_dp <= 1'b1;
    wait_cycles(SettleCycles);
    expect_state(usb_link_pkg::LinkActiveNoSof);
    expect_level(LvlReset, 1'b0);
    // Short SE0 never reaches the reset timeout
    usb_dp <= 1'b0;
    wait_us(1);
    expect_level(LvlReset, 1'b0);
    usb_dp <= 1'b1;
    wait_cycles(SettleCycles);
    expect_state(usb_link_pkg::LinkActiveNoSof);
    wait_cycles(random_gap(20));
    pulse_sof();
    wait_cycles(1);
    expect_state(usb_link_pkg::LinkActive);

    // Idle bus, then activity and a J
    test_name = "suspend_resume";
    clear_observed();
    rx_idle_det <= 1'b1;
    wait_us(SuspendWaitUs);
    expect_state(usb_link_pkg::LinkSuspended);
    expect_level(LvlSuspend, 1'b1);
    rx_idle_det <= 1'b0;
    wait_cycles(2);
    expect_state(usb_link_pkg::LinkResuming);
    rx_j_det <= 1'b1;
    // Resume pulse while the J ends resume signaling
    expect_level(LvlResume, 1'b1);
    rx_j_det <= 1'b0;
    expect_state(usb_link_pkg::LinkActiveNoSof);
    expect_events(event_mask(usb_line_pkg::EvtResume));

    // No frames at all until the host counts as lost
    test_name = "missed_frames";
    clear_observed();
    wait_us(MissWaitUs);
    expect_misses(int'(usb_link_pkg::HostLostFrames));
    expect_level(LvlHostLost, 1'b1);
    expect_events(event_mask(usb_line_pkg::EvtSofMissed) |
                  event_mask(usb_line_pkg::EvtHostLost));
    wait_cycles(random_gap(20));
    pulse_sof();
    wait_cycles(1);
    expect_level(LvlHostLost, 1'b0);
    expect_state(usb_link_pkg::LinkActive);

    wait_cycles(4);
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
